// ==== verilog/b14_config.svh ====
`ifndef B14_CONFIG_SVH
`define B14_CONFIG_SVH

// bus and word widths.
`define B14_ADDR_W     20
`define B14_DATA_W     32

// add, subtract and negate wrap here.
`define B14_ARITH_W    30

// pc step keeps the low bits, then adds.
`define B14_PC_KEEP_W  29
`define B14_PC_STEP    8

// instruction fields, lsb positions.
`define B14_SRC_LSB    29
`define B14_MODE_LSB   27
`define B14_DST_LSB    24
`define B14_CLASS_BIT  23
`define B14_FUNC_LSB   19  // overlaps tail bit 19.
`define B14_TAIL_W     20

`endif

// ==== verilog/b14_pkg.sv ====
`include "b14_config.svh"

package b14_pkg;

  typedef logic [`B14_DATA_W-1:0] word_t;
  typedef logic [`B14_ADDR_W-1:0] addr_t;

  typedef enum logic [1:0] {
    FETCH,
    LOAD_IR,
    OPERAND,
    EXEC
  } state_t;

  // catch-all first, then register ops and the store.
  typedef enum logic [2:0] {
    OP_NOP,
    OP_NEG,
    OP_LINK,
    OP_LOAD,
    OP_ADD,
    OP_SUB,
    OP_STORE
  } op_t;

  typedef enum logic [1:0] {
    MODE_IMM,
    MODE_DIRECT,
    MODE_IDX1,
    MODE_IDX2
  } mode_t;

  typedef enum logic [1:0] {R0, R1, R2, R3} reg_sel_t;  // r3 is the pc.

endpackage

// ==== verilog/b14_decode_if.sv ====
`timescale 1ns/100ps

interface b14_decode_if;
  import b14_pkg::*;

  op_t      op;
  mode_t    mode;
  reg_sel_t src;
  reg_sel_t dst;
  addr_t    tail;

  modport decoder (output op, mode, src, dst, tail);
  modport user (input op, mode, src, dst, tail);

endinterface

// ==== verilog/b14_control.sv ====
`timescale 1ns/100ps

module b14_control (
  input  logic            clock,
  input  logic            reset,
  b14_decode_if.user      dec,
  output b14_pkg::state_t state,
  output logic            step
);
  import b14_pkg::*;

  state_t next_state;
  logic   reg_op;
  logic   need_operand;

  assign reg_op = (dec.op == OP_NEG) || (dec.op == OP_LINK) || (dec.op == OP_LOAD) ||
                  (dec.op == OP_ADD) || (dec.op == OP_SUB);

  // decode is valid from datai already in LOAD_IR.
  assign need_operand = reg_op && (dec.mode != MODE_IMM);

  assign step = (state == LOAD_IR);

  always_comb
  begin
    case (state)
      FETCH:
        next_state = LOAD_IR;
      LOAD_IR:
        next_state = need_operand ? OPERAND : EXEC;
      OPERAND:
        next_state = EXEC;
      default:
        next_state = FETCH;
    endcase
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      state <= FETCH;
    else
      state <= next_state;
  end

endmodule

// ==== verilog/b14_pc.sv ====
`timescale 1ns/100ps
`include "b14_config.svh"

module b14_pc (
  input  logic           clock,
  input  logic           reset,
  input  logic           step,
  input  logic           pc_load,
  input  b14_pkg::word_t pc_data,
  output b14_pkg::word_t pc
);
  import b14_pkg::*;

  word_t pc_next_step;

  // upper bits drop before the step.
  assign pc_next_step = word_t'(pc[`B14_PC_KEEP_W-1:0]) + word_t'(`B14_PC_STEP);

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      pc <= '0;
    else if (pc_load)
      pc <= pc_data;  // jump beats step.
    else if (step)
      pc <= pc_next_step;
  end

endmodule

// ==== verilog/b14_decode.sv ====
`timescale 1ns/100ps
`include "b14_config.svh"

module b14_decode (
  input  logic            clock,
  input  logic            reset,
  input  b14_pkg::state_t state,
  input  b14_pkg::word_t  datai,
  b14_decode_if.decoder   dec
);
  import b14_pkg::*;

  word_t      ir;
  word_t      raw;
  word_t      word;
  logic [2:0] dst_f;
  logic [3:0] func_f;
  logic       class_f;
  op_t        op_c;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      ir <= '0;
    else if (state == LOAD_IR)
      ir <= datai;
  end

  // bypass so the sequencer sees the new word in LOAD_IR.
  assign raw  = (state == LOAD_IR) ? datai : ir;
  assign word = raw[`B14_DATA_W-1] ? -raw : raw;  // sign-magnitude fixup.

  assign dst_f   = word[`B14_DST_LSB +: 3];
  assign func_f  = word[`B14_FUNC_LSB +: 4];
  assign class_f = word[`B14_CLASS_BIT];

  always_comb
  begin
    op_c = OP_NOP;
    if (!class_f)
    begin
      if (dst_f == 3'd7)
        op_c = OP_STORE;
      else if (dst_f <= 3'd3)
        case (func_f)
          4'd0:                   op_c = OP_NEG;
          4'd1:                   op_c = OP_LINK;
          4'd2, 4'd3:             op_c = OP_LOAD;
          4'd4, 4'd5, 4'd8, 4'd10: op_c = OP_ADD;
          4'd6, 4'd7, 4'd9, 4'd11: op_c = OP_SUB;
          default:                op_c = OP_NOP;  // old shift group.
        endcase
    end
  end

  assign dec.op   = op_c;
  assign dec.src  = reg_sel_t'(word[`B14_SRC_LSB +: 2]);
  assign dec.mode = mode_t'(word[`B14_MODE_LSB +: 2]);
  assign dec.dst  = reg_sel_t'(dst_f[1:0]);
  assign dec.tail = word[`B14_TAIL_W-1:0];

endmodule

// ==== verilog/b14_regfile.sv ====
`timescale 1ns/100ps

module b14_regfile (
  input  logic           clock,
  input  logic           reset,
  input  logic           wb_en,
  input  b14_pkg::word_t pc,
  input  b14_pkg::word_t wb_data,
  b14_decode_if.user     dec,
  output b14_pkg::word_t r,
  output b14_pkg::word_t reg1,
  output b14_pkg::word_t reg2,
  output b14_pkg::word_t pc_data,
  output logic           pc_load
);
  import b14_pkg::*;

  word_t reg0;

  always_comb
  begin
    case (dec.src)
      R0:      r = reg0;
      R1:      r = reg1;
      R2:      r = reg2;
      default: r = pc;
    endcase
  end

  // link saves the stepped pc in reg2 while the pc takes m.
  assign pc_load = wb_en && ((dec.op == OP_LINK) || (dec.dst == R3));
  assign pc_data = wb_data;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      reg0 <= '0;
      reg1 <= '0;
      reg2 <= '0;
    end
    else if (wb_en)
    begin
      if (dec.op == OP_LINK)
        reg2 <= pc;
      else
        case (dec.dst)
          R0:      reg0 <= wb_data;
          R1:      reg1 <= wb_data;
          R2:      reg2 <= wb_data;
          default: ;  // r3 goes out as pc_load.
        endcase
    end
  end

endmodule

// ==== verilog/b14_alu.sv ====
`timescale 1ns/100ps
`include "b14_config.svh"

module b14_alu (
  input  b14_pkg::state_t state,
  input  b14_pkg::word_t  datai,
  input  b14_pkg::word_t  r,
  input  b14_pkg::word_t  pc,
  b14_decode_if.user      dec,
  output logic            wb_en,
  output b14_pkg::word_t  wb_data
);
  import b14_pkg::*;

  word_t                   m;
  logic [`B14_ARITH_W-1:0] sum;
  logic [`B14_ARITH_W-1:0] diff;
  logic [`B14_ARITH_W-1:0] neg;

  // memory operand is on datai during EXEC.
  assign m = (dec.mode == MODE_IMM) ? word_t'(dec.tail) : datai;

  assign sum  = r[`B14_ARITH_W-1:0] + m[`B14_ARITH_W-1:0];
  assign diff = r[`B14_ARITH_W-1:0] - m[`B14_ARITH_W-1:0];
  assign neg  = '0 - m[`B14_ARITH_W-1:0];

  always_comb
  begin
    wb_en = 1'b0;
    wb_data = m;
    case (dec.op)
      OP_NEG:
      begin
        wb_en = 1'b1;
        wb_data = word_t'(neg);
      end
      OP_LINK, OP_LOAD:
        wb_en = 1'b1;  // link writes m into the pc.
      OP_ADD:
      begin
        wb_en = 1'b1;
        wb_data = word_t'(sum);
      end
      OP_SUB:
      begin
        wb_en = 1'b1;
        wb_data = word_t'(diff);
      end
      default:
        wb_data = pc;  // stores and nops write nothing.
    endcase
    if (state != EXEC)
      wb_en = 1'b0;
  end

endmodule

// ==== verilog/b14_bus.sv ====
`timescale 1ns/100ps
`include "b14_config.svh"

module b14_bus (
  input  b14_pkg::state_t state,
  input  b14_pkg::word_t  pc,
  input  b14_pkg::word_t  r,
  input  b14_pkg::word_t  reg1,
  input  b14_pkg::word_t  reg2,
  b14_decode_if.user      dec,
  output b14_pkg::addr_t  addr,
  output logic            rd,
  output logic            wr,
  output b14_pkg::word_t  datao
);
  import b14_pkg::*;

  addr_t ea;

  // indexed sums wrap at the bus width.
  always_comb
  begin
    case (dec.mode)
      MODE_IDX1: ea = dec.tail + reg1[`B14_ADDR_W-1:0];
      MODE_IDX2: ea = dec.tail + reg2[`B14_ADDR_W-1:0];
      default:   ea = dec.tail;
    endcase
  end

  assign addr  = (state == FETCH) ? pc[`B14_ADDR_W-1:0] : ea;
  assign rd    = (state == FETCH) || (state == OPERAND);
  assign wr    = (state == EXEC) && (dec.op == OP_STORE);
  assign datao = wr ? r : '0;

endmodule

// ==== verilog/b14_top.sv ====
`timescale 1ns/100ps

module b14_top (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] datai,
  output logic [19:0] addr,
  output logic        rd,
  output logic        wr,
  output logic [31:0] datao
);
  import b14_pkg::*;

  state_t state;
  logic   step;
  logic   wb_en;
  logic   pc_load;
  word_t  wb_data;
  word_t  pc_data;
  word_t  pc;
  word_t  r;
  word_t  reg1;
  word_t  reg2;

  b14_decode_if dec ();

  b14_control u_control (
    .clock (clock),
    .reset (reset),
    .dec   (dec.user),
    .state (state),
    .step  (step)
  );

  b14_pc u_pc (
    .clock   (clock),
    .reset   (reset),
    .step    (step),
    .pc_load (pc_load),
    .pc_data (pc_data),
    .pc      (pc)
  );

  b14_decode u_decode (
    .clock (clock),
    .reset (reset),
    .state (state),
    .datai (datai),
    .dec   (dec.decoder)
  );

  b14_regfile u_regfile (
    .clock   (clock),
    .reset   (reset),
    .wb_en   (wb_en),
    .pc      (pc),
    .wb_data (wb_data),
    .dec     (dec.user),
    .r       (r),
    .reg1    (reg1),
    .reg2    (reg2),
    .pc_data (pc_data),
    .pc_load (pc_load)
  );

  b14_alu u_alu (
    .state   (state),
    .datai   (datai),
    .r       (r),
    .pc      (pc),
    .dec     (dec.user),
    .wb_en   (wb_en),
    .wb_data (wb_data)
  );

  b14_bus u_bus (
    .state (state),
    .pc    (pc),
    .r     (r),
    .reg1  (reg1),
    .reg2  (reg2),
    .dec   (dec.user),
    .addr  (addr),
    .rd    (rd),
    .wr    (wr),
    .datao (datao)
  );

endmodule

// ==== dv/b14_tb.sv ====
`timescale 1ns/100ps

module b14_tb;
  import b14_pkg::*;

  logic        clock;
  logic        reset;
  logic [31:0] datai;
  logic [19:0] addr;
  logic        rd;
  logic        wr;
  logic [31:0] datao;

  logic [31:0] seed;
  word_t       init_mem [addr_t];
  word_t       dut_mem [addr_t];
  word_t       model_mem [addr_t];
  word_t       m_reg [0:3];  // pc kept apart in m_pc.
  word_t       m_pc;
  int          checks;
  int          errors;
  int          stores;
  int          links;
  int          operands;
  bit          hung;

  b14_top UUT (
    .clock (clock),
    .reset (reset),
    .datai (datai),
    .addr  (addr),
    .rd    (rd),
    .wr    (wr),
    .datao (datao)
  );

  initial
  begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic word_t next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return {seed[15:0], seed[31:16]};  // weak low bits moved up.
  endfunction

  // mostly register ops and stores.
  function automatic word_t random_instr();
    word_t w;
    word_t c;
    w = next_rand();
    c = next_rand();
    w[31] = 1'b0;
    case (c[3:0])
      4'd0, 4'd1, 4'd2, 4'd3: w[26:24] = 3'd7;
      4'd4, 4'd5, 4'd6:       w[26:24] = c[2:0];  // dropped flag destinations.
      default:                w[26:24] = {1'b0, c[5:4]};
    endcase
    w[23] = (c[11:8] == 4'd0);
    w[22:19] = (c[15:13] == 3'd0) ? 4'd12 + {2'b00, c[17:16]} : c[21:18] % 4'd12;
    if (c[27:25] == 3'd0)
      w = -w;  // sign-magnitude form.
    return w;
  endfunction

  function automatic word_t initial_word(input addr_t a, input bit fetch);
    if (!init_mem.exists(a))
      init_mem[a] = fetch ? random_instr() : next_rand();
    return init_mem[a];
  endfunction

  function automatic word_t model_read(input addr_t a, input bit fetch);
    return model_mem.exists(a) ? model_mem[a] : initial_word(a, fetch);
  endfunction

  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks = checks + 1;
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    checks = checks + 1;
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_state(input state_t got, input state_t exp, input string what);
    checks = checks + 1;
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("FAILED at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic wait_bus(input bit want_wr);
    int n;
    n = 0;
    while (!hung && !(want_wr ? wr : rd))
    begin
      if (want_wr ? rd : wr)
      begin
        errors = errors + 1;
        $display("unexpected bus %s at %0t", want_wr ? "read" : "write", $time);
      end
      @(negedge clock);
      n = n + 1;
      if (n > 8)
      begin
        $display("timeout: no bus %s within 8 cycles at %0t", want_wr ? "write" : "read", $time);
        hung = 1'b1;
      end
    end
  endtask

  // datai holds until the next read.
  task automatic serve_read(input bit fetch);
    datai = dut_mem.exists(addr) ? dut_mem[addr] : initial_word(addr, fetch);
    @(negedge clock);
  endtask

  task automatic write_reg(input logic [1:0] sel, input word_t value);
    if (sel == 2'd3)
      m_pc = value;
    else
      m_reg[sel] = value;
  endtask

  task automatic run_instruction;
    word_t       w;
    word_t       m;
    word_t       r;
    logic [29:0] a30;
    addr_t       ea;
    addr_t       tail;
    mode_t       mode;
    op_t         op;
    logic [2:0]  dst;
    wait_bus(1'b0);
    if (hung)
      return;
    check_addr(addr, m_pc[19:0], "fetch address");
    serve_read(1'b1);
    w = model_read(m_pc[19:0], 1'b1);
    if (w[31])
      w = -w;
    mode = mode_t'(w[28:27]);
    dst  = w[26:24];
    tail = w[19:0];
    op   = OP_NOP;
    if (!w[23] && dst == 3'd7)
      op = OP_STORE;
    else if (!w[23] && dst <= 3'd3)
      case (w[22:19])
        4'd0:                    op = OP_NEG;
        4'd1:                    op = OP_LINK;
        4'd2, 4'd3:              op = OP_LOAD;
        4'd4, 4'd5, 4'd8, 4'd10: op = OP_ADD;
        4'd6, 4'd7, 4'd9, 4'd11: op = OP_SUB;
        default:                 op = OP_NOP;
      endcase
    m_pc = word_t'(m_pc[28:0]) + 32'd8;
    r = (w[30:29] == 2'd3) ? m_pc : m_reg[w[30:29]];
    case (mode)
      MODE_IDX1: ea = tail + m_reg[1][19:0];
      MODE_IDX2: ea = tail + m_reg[2][19:0];
      default:   ea = tail;
    endcase
    m = {12'd0, tail};
    if (op != OP_NOP && op != OP_STORE && mode != MODE_IMM)
    begin
      wait_bus(1'b0);
      if (hung)
        return;
      check_addr(addr, ea, "operand address");
      serve_read(1'b0);
      m = model_read(ea, 1'b0);
      operands++;
    end
    a30 = (op == OP_ADD) ? r[29:0] + m[29:0] :
          (op == OP_SUB) ? r[29:0] - m[29:0] : 30'd0 - m[29:0];
    if (op == OP_NEG || op == OP_ADD || op == OP_SUB)
      write_reg(dst[1:0], {2'b00, a30});
    else if (op == OP_LOAD)
      write_reg(dst[1:0], m);
    else if (op == OP_LINK)
    begin
      m_reg[2] = m_pc;  // return address.
      m_pc = m;
      links++;
    end
    else if (op == OP_STORE)
    begin
      wait_bus(1'b1);
      if (hung)
        return;
      check_addr(addr, ea, "store address");
      check_word(datao, r, "store data");
      dut_mem[addr] = datao;
      model_mem[ea] = r;
      stores++;
      @(negedge clock);
    end
  endtask

  initial
  begin
    int mark;
    int i;
    reset = 1'b1;
    datai = '0;
    seed = 32'h2556;
    checks = 0;
    errors = 0;
    stores = 0;
    links = 0;
    operands = 0;
    hung = 1'b0;
    m_pc = '0;
    for (i = 0; i < 4; i++)
      m_reg[i] = '0;
    repeat (4) @(negedge clock);
    check_state(UUT.state, FETCH, "state in reset");
    check_word(datao, '0, "datao in reset");
    check_word(word_t'(wr), '0, "wr in reset");
    reset = 1'b0;
    check_word(word_t'(rd), 32'd1, "rd after reset");
    check_addr(addr, '0, "first fetch address");
    $display("test reset: %0d errors", errors);

    mark = errors;
    for (i = 0; i < 300 && !hung; i++)
      run_instruction();
    $display("test random program: %0d instructions, %0d stores, %0d links, %0d reads, %0d errors",
             i, stores, links, operands, errors - mark);

    mark = errors;
    foreach (dut_mem[a])
    begin
      if (!model_mem.exists(a))
      begin
        errors = errors + 1;
        $display("memory write to %h was not expected by the model", a);
      end
      else
        check_word(dut_mem[a], model_mem[a], $sformatf("memory word at %h", a));
    end
    check_word(word_t'(dut_mem.num()), word_t'(model_mem.num()), "written word count");
    $display("test memory compare: %0d words, %0d errors", dut_mem.num(), errors - mark);

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !hung)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== b14.f ====
+incdir+verilog
verilog/b14_pkg.sv
verilog/b14_decode_if.sv
verilog/b14_control.sv
verilog/b14_pc.sv
verilog/b14_decode.sv
verilog/b14_regfile.sv
verilog/b14_alu.sv
verilog/b14_bus.sv
verilog/b14_top.sv
dv/b14_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = b14_tb
FILELIST = b14.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
